// ==== cmd_issue.sv ====
`timescale 1ns/1ns
`include "ddr_macros.svh"

module cmd_issue (
	input  logic clk,
	input  logic rst_n,
	input  logic grant_valid_i,
	input  logic [$clog2(`DDR_SLOTS)-1:0] grant_slot_i,
	input  ddr_types_pkg::cmd_t grant_cmd_i,
	input  logic [`DDR_SLOTS-1:0][ddr_types_pkg::BANK_W-1:0] slot_bank_i,
	input  logic [`DDR_SLOTS-1:0][ddr_types_pkg::ROW_W-1:0] slot_row_i,
	output logic cmd_valid_o,
	output ddr_types_pkg::cmd_t cmd_o,
	output logic [ddr_types_pkg::BANK_W-1:0] cmd_bank_o,
	output logic [ddr_types_pkg::ROW_W-1:0] cmd_row_o,
	output logic done_o,
	output logic [$clog2(`DDR_SLOTS)-1:0] done_slot_o
);
	import ddr_types_pkg::*;

	localparam int SLOT_W = $clog2(`DDR_SLOTS);

	logic [`DDR_SLOTS-1:0] busy; // data window running
	logic [`DDR_SLOTS-1:0][`DDR_CNT_W-1:0] win_cnt;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			cmd_valid_o <= 1'b0;
			cmd_o <= none;
		end else begin
			cmd_valid_o <= grant_valid_i;
			cmd_o <= grant_valid_i ? grant_cmd_i : none;
		end
	end

	always_ff @(posedge clk) begin
		if (grant_valid_i) begin
			cmd_bank_o <= slot_bank_i[grant_slot_i];
			cmd_row_o <= slot_row_i[grant_slot_i];
		end
	end

	// lowest finished slot reports first
	always_comb begin
		done_o = 1'b0;
		done_slot_o = '0;
		for (int s = `DDR_SLOTS - 1; s >= 0; s--) begin
			if (busy[s] && win_cnt[s] == '0) begin
				done_o = 1'b1;
				done_slot_o = SLOT_W'(s);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			busy <= '0;
		end else begin
			for (int s = 0; s < `DDR_SLOTS; s++) begin
				if (done_o && done_slot_o == SLOT_W'(s)) begin
					busy[s] <= 1'b0;
				end
				if (grant_valid_i && grant_slot_i == SLOT_W'(s) &&
				    (grant_cmd_i == read_cmd || grant_cmd_i == write_cmd)) begin
					busy[s] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < `DDR_SLOTS; s++) begin
			if (grant_valid_i && grant_slot_i == SLOT_W'(s) && grant_cmd_i == read_cmd) begin
				win_cnt[s] <= `DDR_CNT_W'(`DDR_T_CL + `DDR_T_BURST);
			end else if (grant_valid_i && grant_slot_i == SLOT_W'(s) &&
			             grant_cmd_i == write_cmd) begin
				win_cnt[s] <= `DDR_CNT_W'(`DDR_T_CWL + `DDR_T_BURST);
			end else if (busy[s] && win_cnt[s] != '0) begin
				win_cnt[s] <= win_cnt[s] - 1'b1; // done when it hits zero
			end
		end
	end

endmodule

// ==== compile.f ====
+incdir+.
ddr_types_pkg.sv
request_slots.sv
timing_controller.sv
cmd_issue.sv
mem_sched_top.sv
sched_checker.sv
tb_monitor.sv
tb_mem_sched.sv

// ==== ddr_macros.svh ====
`ifndef DDR_MACROS_SVH
`define DDR_MACROS_SVH

// request slots and counter sizing
`define DDR_SLOTS 4 // request slots in the scheduler
`define DDR_CNT_W 5 // saturating timing counter width
`define DDR_T_MAX 20 // saturation value, covers the longest limit

// same bank limits, in clock cycles
`define DDR_T_RCD 6 // activate to read or write
`define DDR_T_RP 6 // precharge to activate
`define DDR_T_RC 20 // activate to activate
`define DDR_T_RAS 14 // activate to precharge
`define DDR_T_RTP 3 // read to precharge
`define DDR_T_WR 6 // write to precharge

// same bank group
`define DDR_T_RRD 3 // activate to activate

// any bank
`define DDR_T_RTW 5 // read to write turnaround
`define DDR_T_WTR 9 // write to read turnaround
`define DDR_T_CCD 2 // column to column

// data bus
`define DDR_T_CL 6 // read latency
`define DDR_T_CWL 4 // write latency
`define DDR_T_BURST 8 // burst length on the bus

`endif

// ==== ddr_types_pkg.sv ====
package ddr_types_pkg;

	// bank address is {group[1:0], bank[1:0]}
	parameter int BANK_W = 4;
	parameter int ROW_W = 8;

	typedef enum logic [2:0] {
		none,
		activate,
		read_cmd,
		write_cmd,
		precharge
	} cmd_t;

	typedef enum logic [1:0] {
		empty,
		waiting, // holds a request, no column command yet
		in_flight // column command sent, data window running
	} slot_state_t;

	typedef enum logic {
		rd,
		wr
	} req_type_t;

endpackage

// ==== mem_sched_top.sv ====
`timescale 1ns/1ns
`include "ddr_macros.svh"

module mem_sched_top (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid_i,
	input  ddr_types_pkg::req_type_t req_type_i,
	input  logic [ddr_types_pkg::BANK_W-1:0] req_bank_i,
	input  logic [ddr_types_pkg::ROW_W-1:0] req_row_i,
	output logic req_ready_o,
	output logic cmd_valid_o,
	output ddr_types_pkg::cmd_t cmd_o,
	output logic [ddr_types_pkg::BANK_W-1:0] cmd_bank_o,
	output logic [ddr_types_pkg::ROW_W-1:0] cmd_row_o,
	output logic done_o,
	output logic [$clog2(`DDR_SLOTS)-1:0] done_slot_o
);
	import ddr_types_pkg::*;

	slot_state_t [`DDR_SLOTS-1:0] slot_state;
	req_type_t [`DDR_SLOTS-1:0] slot_type;
	logic [`DDR_SLOTS-1:0][BANK_W-1:0] slot_bank;
	logic [`DDR_SLOTS-1:0][ROW_W-1:0] slot_row;
	logic grant_valid;
	logic [$clog2(`DDR_SLOTS)-1:0] grant_slot;
	cmd_t grant_cmd;

	request_slots u_slots (
		.clk(clk), .rst_n(rst_n),
		.req_valid_i(req_valid_i), .req_type_i(req_type_i),
		.req_bank_i(req_bank_i), .req_row_i(req_row_i),
		.grant_valid_i(grant_valid), .grant_slot_i(grant_slot), .grant_cmd_i(grant_cmd),
		.done_i(done_o), .done_slot_i(done_slot_o),
		.req_ready_o(req_ready_o), .slot_state_o(slot_state), .slot_type_o(slot_type),
		.slot_bank_o(slot_bank), .slot_row_o(slot_row)
	);

	timing_controller #(.NUM_SLOTS(`DDR_SLOTS)) u_timing (
		.clk(clk), .rst_n(rst_n),
		.slot_state_i(slot_state), .slot_type_i(slot_type),
		.slot_bank_i(slot_bank), .slot_row_i(slot_row),
		.grant_valid_o(grant_valid), .grant_slot_o(grant_slot), .grant_cmd_o(grant_cmd)
	);

	cmd_issue u_issue (
		.clk(clk), .rst_n(rst_n),
		.grant_valid_i(grant_valid), .grant_slot_i(grant_slot), .grant_cmd_i(grant_cmd),
		.slot_bank_i(slot_bank), .slot_row_i(slot_row),
		.cmd_valid_o(cmd_valid_o), .cmd_o(cmd_o), .cmd_bank_o(cmd_bank_o),
		.cmd_row_o(cmd_row_o), .done_o(done_o), .done_slot_o(done_slot_o)
	);

endmodule

// ==== request_slots.sv ====
`timescale 1ns/1ns
`include "ddr_macros.svh"

module request_slots (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid_i,
	input  ddr_types_pkg::req_type_t req_type_i,
	input  logic [ddr_types_pkg::BANK_W-1:0] req_bank_i,
	input  logic [ddr_types_pkg::ROW_W-1:0] req_row_i,
	input  logic grant_valid_i,
	input  logic [$clog2(`DDR_SLOTS)-1:0] grant_slot_i,
	input  ddr_types_pkg::cmd_t grant_cmd_i,
	input  logic done_i,
	input  logic [$clog2(`DDR_SLOTS)-1:0] done_slot_i,
	output logic req_ready_o,
	output ddr_types_pkg::slot_state_t [`DDR_SLOTS-1:0] slot_state_o,
	output ddr_types_pkg::req_type_t [`DDR_SLOTS-1:0] slot_type_o,
	output logic [`DDR_SLOTS-1:0][ddr_types_pkg::BANK_W-1:0] slot_bank_o,
	output logic [`DDR_SLOTS-1:0][ddr_types_pkg::ROW_W-1:0] slot_row_o
);
	import ddr_types_pkg::*;

	localparam int SLOT_W = $clog2(`DDR_SLOTS);

	logic [`DDR_SLOTS-1:0] free_v;
	logic [SLOT_W-1:0] free_idx;
	logic accept;
	logic col_grant;

	// lowest empty slot takes the next request
	always_comb begin
		free_idx = '0;
		for (int s = `DDR_SLOTS - 1; s >= 0; s--) begin
			free_v[s] = (slot_state_o[s] == empty);
			if (free_v[s]) begin
				free_idx = SLOT_W'(s);
			end
		end
	end

	assign req_ready_o = |free_v;
	assign accept = req_valid_i && req_ready_o;
	assign col_grant = grant_valid_i && (grant_cmd_i == read_cmd || grant_cmd_i == write_cmd);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int s = 0; s < `DDR_SLOTS; s++) begin
				slot_state_o[s] <= empty;
			end
		end else begin
			for (int s = 0; s < `DDR_SLOTS; s++) begin
				case (slot_state_o[s])
					empty: begin
						if (accept && free_idx == SLOT_W'(s)) begin
							slot_state_o[s] <= waiting;
						end
					end
					waiting: begin
						if (col_grant && grant_slot_i == SLOT_W'(s)) begin
							slot_state_o[s] <= in_flight; // act and pre keep it waiting
						end
					end
					in_flight: begin
						if (done_i && done_slot_i == SLOT_W'(s)) begin
							slot_state_o[s] <= empty;
						end
					end
					default: slot_state_o[s] <= empty;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			slot_type_o[free_idx] <= req_type_i;
			slot_bank_o[free_idx] <= req_bank_i;
			slot_row_o[free_idx] <= req_row_i;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mem_sched -f compile.f -o tb_sim && \
	out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Verification passed" && exit 0 || exit 1

// ==== sched_checker.sv ====
`timescale 1ns/1ns

module sched_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid_i,
	input  logic req_ready_i,
	input  logic cmd_valid_i,
	input  ddr_types_pkg::cmd_t cmd_i,
	input  logic done_i
);
	import ddr_types_pkg::*;

	int assert_fails = 0; // failed assertion count

	cmd_has_opcode: assert property (@(posedge clk) disable iff (rst_n)
		cmd_valid_i |-> cmd_i != none)
		else begin
			assert_fails++;
			$error("command strobe carries no command");
		end

	done_single_cycle: assert property (@(posedge clk) disable iff (rst_n)
		done_i |=> !done_i)
		else begin
			assert_fails++;
			$error("done pulse longer than one cycle");
		end

	req_only_when_ready: assert property (@(posedge clk) disable iff (rst_n)
		!(req_valid_i && !req_ready_i))
		else begin
			assert_fails++;
			$error("request strobe while the scheduler is not ready");
		end

	quiet_after_reset: assert property (@(posedge clk)
		$fell(rst_n) |-> !cmd_valid_i && !done_i)
		else begin
			assert_fails++;
			$error("command or done active right after reset");
		end

endmodule

bind mem_sched_top sched_checker u_chk (
	.clk(clk), .rst_n(rst_n),
	.req_valid_i(req_valid_i), .req_ready_i(req_ready_o),
	.cmd_valid_i(cmd_valid_o), .cmd_i(cmd_o), .done_i(done_o)
);

// ==== tb_mem_sched.sv ====
`timescale 1ns/1ns
`include "ddr_macros.svh"

module tb_mem_sched;
	import ddr_types_pkg::*;

	localparam int TBL_LEN = 12;
	localparam int RAND_REQS = 24;
	localparam int NUM_TESTS = TBL_LEN + RAND_REQS;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 80;

	typedef struct packed {
		req_type_t rtype;
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0] row;
		logic [7:0] gap; // idle cycles after the request
		logic [1:0] exp_cmds; // commands the request needs
	} stim_t;

	stim_t stim_tbl [TBL_LEN] = '{
		'{rd, 4'd0, 8'd10, 8'd30, 2'd2}, // closed bank
		'{rd, 4'd0, 8'd10, 8'd30, 2'd1}, // row hit
		'{wr, 4'd0, 8'd10, 8'd30, 2'd1},
		'{rd, 4'd0, 8'd20, 8'd30, 2'd3}, // row miss
		'{wr, 4'd5, 8'd3, 8'd0, 2'd2}, // four banks back to back fill every slot
		'{rd, 4'd6, 8'd4, 8'd0, 2'd2},
		'{wr, 4'd9, 8'd7, 8'd0, 2'd2},
		'{rd, 4'd14, 8'd8, 8'd0, 2'd2},
		'{rd, 4'd5, 8'd3, 8'd0, 2'd1},
		'{wr, 4'd5, 8'd9, 8'd0, 2'd3},
		'{wr, 4'd4, 8'd1, 8'd0, 2'd2}, // same group as bank 5
		'{rd, 4'd0, 8'd20, 8'd20, 2'd1}
	};

	logic clk;
	logic rst_n;
	logic req_valid;
	req_type_t req_type;
	logic [BANK_W-1:0] req_bank;
	logic [ROW_W-1:0] req_row;
	logic [1:0] exp_cmds;
	logic req_ready;
	logic cmd_valid;
	cmd_t cmd;
	logic [BANK_W-1:0] cmd_bank;
	logic [ROW_W-1:0] cmd_row;
	logic done;
	logic [$clog2(`DDR_SLOTS)-1:0] done_slot;
	int pass_cnt;
	int fail_cnt;
	int err_cnt;
	int done_cnt;
	int seed;
	logic [(1 << BANK_W)-1:0] seen_open; // rows the requests leave open
	logic [ROW_W-1:0] seen_row [1 << BANK_W];

	mem_sched_top u_dut (
		.clk(clk), .rst_n(rst_n),
		.req_valid_i(req_valid), .req_type_i(req_type),
		.req_bank_i(req_bank), .req_row_i(req_row), .req_ready_o(req_ready),
		.cmd_valid_o(cmd_valid), .cmd_o(cmd), .cmd_bank_o(cmd_bank), .cmd_row_o(cmd_row),
		.done_o(done), .done_slot_o(done_slot)
	);

	tb_monitor u_mon (
		.clk(clk), .rst_n(rst_n),
		.req_valid_i(req_valid), .req_ready_i(req_ready), .req_type_i(req_type),
		.req_bank_i(req_bank), .req_row_i(req_row), .exp_cmds_i(exp_cmds),
		.cmd_valid_i(cmd_valid), .cmd_i(cmd), .cmd_bank_i(cmd_bank), .cmd_row_i(cmd_row),
		.done_i(done), .done_slot_i(done_slot),
		.pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt), .err_cnt_o(err_cnt), .done_cnt_o(done_cnt)
	);

	always #2 clk = ~clk;

	// closed bank needs act+col, same row col only, other row pre+act+col
	function automatic logic [1:0] cmds_for(input logic [BANK_W-1:0] bank,
	                                        input logic [ROW_W-1:0] row);
		if (!seen_open[bank]) begin
			return 2'd2;
		end else if (seen_row[bank] == row) begin
			return 2'd1;
		end
		return 2'd3;
	endfunction

	task automatic note_row(input logic [BANK_W-1:0] bank, input logic [ROW_W-1:0] row);
		seen_open[bank] = 1'b1;
		seen_row[bank] = row;
	endtask

	// valid is low here, so ready can only stay or rise at this edge
	task automatic send_request(input req_type_t rtype, input logic [BANK_W-1:0] bank,
	                            input logic [ROW_W-1:0] row, input int gap,
	                            input logic [1:0] exp);
		@(posedge clk);
		while (!req_ready) begin
			@(posedge clk);
		end
		req_valid <= 1'b1;
		req_type <= rtype;
		req_bank <= bank;
		req_row <= row;
		exp_cmds <= exp;
		@(posedge clk);
		req_valid <= 1'b0;
		repeat (gap) @(posedge clk);
	endtask

	initial begin
		req_type_t rtype;
		logic [BANK_W-1:0] rbank;
		logic [ROW_W-1:0] rrow;
		int rgap;
		clk = 1'b0;
		rst_n = 1'b1;
		req_valid = 1'b0;
		req_type = rd;
		req_bank = '0;
		req_row = '0;
		exp_cmds = '0;
		seed = 3;
		seen_open = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b0;
		for (int i = 0; i < TBL_LEN; i++) begin
			send_request(stim_tbl[i].rtype, stim_tbl[i].bank, stim_tbl[i].row,
			             int'(stim_tbl[i].gap), stim_tbl[i].exp_cmds);
			note_row(stim_tbl[i].bank, stim_tbl[i].row);
		end
		for (int i = 0; i < RAND_REQS; i++) begin
			rtype = ($random(seed) & 1) ? wr : rd;
			rbank = BANK_W'($random(seed));
			rrow = ROW_W'($random(seed) & 3); // few rows so hits and misses mix
			rgap = $random(seed) & 3;
			send_request(rtype, rbank, rrow, rgap, cmds_for(rbank, rrow));
			note_row(rbank, rrow);
		end
		wait (done_cnt >= NUM_TESTS);
		repeat (30) @(posedge clk);
		$display("tests passed %0d, tests failed %0d, check errors %0d, assertion failures %0d",
		         pass_cnt, fail_cnt, err_cnt, u_dut.u_chk.assert_fails);
		if (fail_cnt == 0 && err_cnt == 0 && u_dut.u_chk.assert_fails == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("run timed out after %0d cycles, %0d of %0d requests completed",
		         WATCHDOG_CYCLES, done_cnt, NUM_TESTS);
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== tb_monitor.sv ====
`timescale 1ns/1ns
`include "ddr_macros.svh"

module tb_monitor (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid_i,
	input  logic req_ready_i,
	input  ddr_types_pkg::req_type_t req_type_i,
	input  logic [ddr_types_pkg::BANK_W-1:0] req_bank_i,
	input  logic [ddr_types_pkg::ROW_W-1:0] req_row_i,
	input  logic [1:0] exp_cmds_i,
	input  logic cmd_valid_i,
	input  ddr_types_pkg::cmd_t cmd_i,
	input  logic [ddr_types_pkg::BANK_W-1:0] cmd_bank_i,
	input  logic [ddr_types_pkg::ROW_W-1:0] cmd_row_i,
	input  logic done_i,
	input  logic [$clog2(`DDR_SLOTS)-1:0] done_slot_i,
	output int pass_cnt_o,
	output int fail_cnt_o,
	output int err_cnt_o,
	output int done_cnt_o
);
	import ddr_types_pkg::*;

	localparam int NS = `DDR_SLOTS;
	localparam int NB = 1 << BANK_W;
	localparam int NG = NB / 4;
	localparam int LONG_AGO = -1000;

	int cyc;
	int seq_next;
	logic [NS-1:0] occ; // modelled slot occupancy
	logic [NS-1:0] col_seen;
	logic [NS-1:0] bad;
	req_type_t s_type [NS];
	logic [BANK_W-1:0] s_bank [NS];
	logic [ROW_W-1:0] s_row [NS];
	int s_seq [NS];
	int s_exp [NS];
	int s_cmds [NS];
	int s_col_t [NS];
	logic [NB-1:0] b_open; // bank state as seen on the command port
	logic [ROW_W-1:0] b_row [NB];
	int t_act [NB];
	int t_pre [NB];
	int t_rd [NB];
	int t_wr [NB];
	int t_grp_act [NG];
	int t_rd_any;
	int t_wr_any;

	task automatic flag_error(input int slot, input string msg);
		err_cnt_o++;
		if (slot >= 0) begin
			bad[slot] = 1'b1;
		end
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	task automatic check_spacing(input int slot, input int since, input int min_gap,
	                             input string what);
		if (cyc - since < min_gap) begin
			flag_error(slot, $sformatf("%s spacing %0d, minimum %0d", what, cyc - since, min_gap));
		end
	endtask

	// oldest request of the bank still waiting for its column command
	function automatic int oldest_pending(input logic [BANK_W-1:0] bank, input logic any_type,
	                                      input req_type_t rtype);
		int best;
		best = -1;
		for (int k = 0; k < NS; k++) begin
			if (occ[k] && !col_seen[k] && s_bank[k] == bank && (any_type || s_type[k] == rtype)) begin
				if (best < 0) begin
					best = k;
				end else if (s_seq[k] < s_seq[best]) begin
					best = k;
				end
			end
		end
		return best;
	endfunction

	always @(posedge clk) begin
		int s;
		int g;
		int lat;
		logic [BANK_W-1:0] b;
		if (rst_n) begin
			cyc = 0;
			seq_next = 0;
			occ = '0;
			col_seen = '0;
			bad = '0;
			b_open = '0;
			for (int n = 0; n < NB; n++) begin
				t_act[n] = LONG_AGO;
				t_pre[n] = LONG_AGO;
				t_rd[n] = LONG_AGO;
				t_wr[n] = LONG_AGO;
			end
			for (int n = 0; n < NG; n++) begin
				t_grp_act[n] = LONG_AGO;
			end
			t_rd_any = LONG_AGO;
			t_wr_any = LONG_AGO;
			pass_cnt_o = 0;
			fail_cnt_o = 0;
			err_cnt_o = 0;
			done_cnt_o = 0;
		end else begin
			cyc++;
			if (req_ready_i != !(&occ)) begin
				flag_error(-1, "req_ready_o disagrees with the free slots");
			end
			if (cmd_valid_i) begin
				b = cmd_bank_i;
				g = int'(b[BANK_W-1:BANK_W-2]);
				s = -1;
				case (cmd_i)
					activate: begin
						s = oldest_pending(b, 1'b1, rd);
						if (b_open[b]) begin
							flag_error(s, $sformatf("activate to open bank %0d", b));
						end
						check_spacing(s, t_pre[b], `DDR_T_RP, "precharge to activate");
						check_spacing(s, t_act[b], `DDR_T_RC, "activate to activate, same bank");
						check_spacing(s, t_grp_act[g], `DDR_T_RRD, "activate to activate, same group");
						b_open[b] = 1'b1;
						b_row[b] = cmd_row_i;
						t_act[b] = cyc;
						t_grp_act[g] = cyc;
					end
					precharge: begin
						s = oldest_pending(b, 1'b1, rd);
						if (!b_open[b]) begin
							flag_error(s, $sformatf("precharge to closed bank %0d", b));
						end else if (s >= 0 && s_row[s] == b_row[b]) begin
							flag_error(s, "precharge of the row the oldest request needs");
						end
						check_spacing(s, t_act[b], `DDR_T_RAS, "activate to precharge");
						check_spacing(s, t_rd[b], `DDR_T_RTP, "read to precharge");
						check_spacing(s, t_wr[b], `DDR_T_WR, "write to precharge");
						b_open[b] = 1'b0;
						t_pre[b] = cyc;
					end
					read_cmd, write_cmd: begin
						s = oldest_pending(b, 1'b0, (cmd_i == read_cmd) ? rd : wr);
						if (!b_open[b] || b_row[b] != cmd_row_i) begin
							flag_error(s, $sformatf("column command to bank %0d row %0d not open",
							                        b, cmd_row_i));
						end
						if (s >= 0 && s_row[s] != cmd_row_i) begin
							flag_error(s, "column row differs from the oldest request");
						end
						check_spacing(s, t_act[b], `DDR_T_RCD, "activate to column");
						check_spacing(s, t_rd_any, `DDR_T_CCD, "read to column");
						check_spacing(s, t_wr_any, `DDR_T_CCD, "write to column");
						if (cmd_i == read_cmd) begin
							check_spacing(s, t_wr_any, `DDR_T_WTR, "write to read");
							check_spacing(s, t_wr_any, `DDR_T_CWL + `DDR_T_BURST - `DDR_T_CL,
							              "write data to read data");
							check_spacing(s, t_rd_any, `DDR_T_BURST, "read burst to read burst");
							t_rd[b] = cyc;
							t_rd_any = cyc;
						end else begin
							check_spacing(s, t_rd_any, `DDR_T_RTW, "read to write");
							check_spacing(s, t_rd_any, `DDR_T_CL + `DDR_T_BURST - `DDR_T_CWL,
							              "read data to write data");
							check_spacing(s, t_wr_any, `DDR_T_BURST, "write burst to write burst");
							t_wr[b] = cyc;
							t_wr_any = cyc;
						end
					end
					default: flag_error(-1, "cmd_valid_o high with no command");
				endcase
				if (s >= 0) begin
					s_cmds[s]++;
					if (cmd_i == read_cmd || cmd_i == write_cmd) begin
						col_seen[s] = 1'b1;
						s_col_t[s] = cyc;
						if (s_cmds[s] != s_exp[s]) begin
							flag_error(s, $sformatf("request %0d took %0d commands, expected %0d",
							                        s_seq[s], s_cmds[s], s_exp[s]));
						end
					end
				end else if (cmd_i != none) begin
					flag_error(-1, $sformatf("%s to bank %0d with no pending request",
					                         cmd_i.name(), b));
				end
			end
			// new request lands in the lowest slot that was empty before this edge
			if (req_valid_i && req_ready_i) begin
				s = -1;
				for (int k = NS - 1; k >= 0; k--) begin
					if (!occ[k]) begin
						s = k;
					end
				end
				if (s < 0) begin
					flag_error(-1, "request accepted with all slots full");
				end else begin
					occ[s] = 1'b1;
					col_seen[s] = 1'b0;
					bad[s] = 1'b0;
					s_type[s] = req_type_i;
					s_bank[s] = req_bank_i;
					s_row[s] = req_row_i;
					s_seq[s] = seq_next;
					s_exp[s] = int'(exp_cmds_i);
					s_cmds[s] = 0;
					seq_next++;
				end
			end
			if (done_i) begin
				s = int'(done_slot_i);
				if (!occ[s] || !col_seen[s]) begin
					flag_error(-1, $sformatf("done_o for slot %0d with nothing in flight", s));
				end else begin
					lat = (s_type[s] == rd) ? `DDR_T_CL + `DDR_T_BURST : `DDR_T_CWL + `DDR_T_BURST;
					if (cyc - s_col_t[s] != lat) begin
						flag_error(s, $sformatf("done %0d cycles after the column command, expected %0d",
						                        cyc - s_col_t[s], lat));
					end
					for (int k = 0; k < NS; k++) begin
						if (k != s && occ[k] && s_bank[k] == s_bank[s] && s_seq[k] < s_seq[s]) begin
							flag_error(s, "completion overtakes an older request to the same bank");
						end
					end
					done_cnt_o++;
					if (bad[s]) begin
						fail_cnt_o++;
					end else begin
						pass_cnt_o++;
					end
					$display("test %0d: %s bank %0d row %0d slot %0d, %0d commands, %s", s_seq[s],
					         s_type[s].name(), s_bank[s], s_row[s], s, s_cmds[s],
					         bad[s] ? "error" : "ok");
					occ[s] = 1'b0;
				end
			end
		end
	end

endmodule

// ==== timing_controller.sv ====
`timescale 1ns/1ns
`include "ddr_macros.svh"

module timing_controller #(
	parameter int NUM_SLOTS = `DDR_SLOTS
) (
	input  logic clk,
	input  logic rst_n,
	input  ddr_types_pkg::slot_state_t [NUM_SLOTS-1:0] slot_state_i,
	input  ddr_types_pkg::req_type_t [NUM_SLOTS-1:0] slot_type_i,
	input  logic [NUM_SLOTS-1:0][ddr_types_pkg::BANK_W-1:0] slot_bank_i,
	input  logic [NUM_SLOTS-1:0][ddr_types_pkg::ROW_W-1:0] slot_row_i,
	output logic grant_valid_o,
	output logic [$clog2(NUM_SLOTS)-1:0] grant_slot_o,
	output ddr_types_pkg::cmd_t grant_cmd_o
);
	import ddr_types_pkg::*;

	localparam int SLOT_W = $clog2(NUM_SLOTS);
	localparam int NUM_BANKS = 1 << BANK_W;
	localparam int GRP_LSB = BANK_W - 2;
	localparam int NUM_GRPS = 1 << GRP_LSB;
	// data windows must not overlap on the shared bus
	localparam int RD_BUS_GAP = `DDR_T_CWL + `DDR_T_BURST - `DDR_T_CL; // write data ends first
	localparam int WR_BUS_GAP = `DDR_T_CL + `DDR_T_BURST - `DDR_T_CWL; // read data ends first

	typedef logic [`DDR_CNT_W-1:0] cnt_t;

	cnt_t [NUM_BANKS-1:0] act_cnt, rd_cnt, wr_cnt, pre_cnt; // cycles since last cmd per bank
	cnt_t [NUM_GRPS-1:0] grp_act_cnt;
	cnt_t glb_rd_cnt, glb_wr_cnt;
	logic [NUM_BANKS-1:0][ROW_W-1:0] open_row;
	logic [NUM_BANKS-1:0] open_vld;

	logic [NUM_SLOTS-1:0] wait_v, prev_empty, is_new, blocked, cand_vld;
	logic [NUM_SLOTS-1:0][NUM_SLOTS-1:0] older_q; // [i][j] set when i arrived before j
	cmd_t [NUM_SLOTS-1:0] cand_cmd;
	logic [SLOT_W-1:0] rr_ptr;
	logic [BANK_W-1:0] g_bank;

	function automatic cnt_t sat_inc(input cnt_t c);
		sat_inc = (c == cnt_t'(`DDR_T_MAX)) ? c : c + 1'b1;
	endfunction

	// a grant now lands on the command port one cycle later
	function automatic logic met(input cnt_t c, input int t);
		met = int'(c) >= t - 1;
	endfunction

	// a slot that just arrived is younger than every other waiting slot
	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			wait_v[i] = (slot_state_i[i] == waiting);
			is_new[i] = wait_v[i] && prev_empty[i];
		end
		for (int i = 0; i < NUM_SLOTS; i++) begin
			blocked[i] = 1'b0;
			for (int j = 0; j < NUM_SLOTS; j++) begin
				if (j != i && wait_v[j] && slot_bank_i[j] == slot_bank_i[i] &&
				    (is_new[i] || (!is_new[j] && older_q[j][i]))) begin
					blocked[i] = 1'b1; // older request to the same bank goes first
				end
			end
		end
	end

	// one candidate command per waiting slot
	always_comb begin
		logic [BANK_W-1:0] b;
		logic col_ok;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			b = slot_bank_i[i];
			cand_vld[i] = 1'b0;
			cand_cmd[i] = none;
			if (slot_type_i[i] == rd) begin
				col_ok = met(glb_wr_cnt, `DDR_T_WTR) && met(glb_wr_cnt, RD_BUS_GAP) &&
				         met(glb_rd_cnt, `DDR_T_BURST);
			end else begin
				col_ok = met(glb_rd_cnt, `DDR_T_RTW) && met(glb_rd_cnt, WR_BUS_GAP) &&
				         met(glb_wr_cnt, `DDR_T_BURST);
			end
			col_ok = col_ok && met(glb_rd_cnt, `DDR_T_CCD) && met(glb_wr_cnt, `DDR_T_CCD);
			if (wait_v[i] && !blocked[i]) begin
				if (!open_vld[b]) begin
					if (met(pre_cnt[b], `DDR_T_RP) && met(act_cnt[b], `DDR_T_RC) &&
					    met(grp_act_cnt[b[BANK_W-1:GRP_LSB]], `DDR_T_RRD)) begin
						cand_vld[i] = 1'b1;
						cand_cmd[i] = activate;
					end
				end else if (open_row[b] != slot_row_i[i]) begin
					if (met(act_cnt[b], `DDR_T_RAS) && met(rd_cnt[b], `DDR_T_RTP) &&
					    met(wr_cnt[b], `DDR_T_WR)) begin
						cand_vld[i] = 1'b1;
						cand_cmd[i] = precharge; // row miss
					end
				end else if (met(act_cnt[b], `DDR_T_RCD) && col_ok) begin
					cand_vld[i] = 1'b1;
					cand_cmd[i] = (slot_type_i[i] == rd) ? read_cmd : write_cmd;
				end
			end
		end
	end

	// round robin, search starts at rr_ptr
	always_comb begin
		int idx;
		grant_valid_o = 1'b0;
		grant_slot_o = '0;
		grant_cmd_o = none;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			idx = int'(rr_ptr) + k;
			if (idx >= NUM_SLOTS) begin
				idx = idx - NUM_SLOTS;
			end
			if (cand_vld[idx] && !grant_valid_o) begin
				grant_valid_o = 1'b1;
				grant_slot_o = SLOT_W'(idx);
				grant_cmd_o = cand_cmd[idx];
			end
		end
	end

	assign g_bank = slot_bank_i[grant_slot_o];

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				act_cnt[b] <= cnt_t'(`DDR_T_MAX);
				rd_cnt[b] <= cnt_t'(`DDR_T_MAX);
				wr_cnt[b] <= cnt_t'(`DDR_T_MAX);
				pre_cnt[b] <= cnt_t'(`DDR_T_MAX);
			end
			for (int g = 0; g < NUM_GRPS; g++) begin
				grp_act_cnt[g] <= cnt_t'(`DDR_T_MAX);
			end
			glb_rd_cnt <= cnt_t'(`DDR_T_MAX);
			glb_wr_cnt <= cnt_t'(`DDR_T_MAX);
			open_vld <= '0; // all banks closed
			prev_empty <= '1;
			older_q <= '0;
			rr_ptr <= '0;
		end else begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				act_cnt[b] <= sat_inc(act_cnt[b]);
				rd_cnt[b] <= sat_inc(rd_cnt[b]);
				wr_cnt[b] <= sat_inc(wr_cnt[b]);
				pre_cnt[b] <= sat_inc(pre_cnt[b]);
			end
			for (int g = 0; g < NUM_GRPS; g++) begin
				grp_act_cnt[g] <= sat_inc(grp_act_cnt[g]);
			end
			glb_rd_cnt <= sat_inc(glb_rd_cnt);
			glb_wr_cnt <= sat_inc(glb_wr_cnt);
			for (int n = 0; n < NUM_SLOTS; n++) begin
				prev_empty[n] <= (slot_state_i[n] == empty);
				if (is_new[n]) begin
					for (int j = 0; j < NUM_SLOTS; j++) begin
						older_q[j][n] <= (j != n);
						older_q[n][j] <= 1'b0;
					end
				end
			end
			if (grant_valid_o) begin
				rr_ptr <= (grant_slot_o == SLOT_W'(NUM_SLOTS - 1)) ? '0 : grant_slot_o + 1'b1;
				case (grant_cmd_o)
					activate: begin
						act_cnt[g_bank] <= '0;
						grp_act_cnt[g_bank[BANK_W-1:GRP_LSB]] <= '0;
						open_vld[g_bank] <= 1'b1;
					end
					read_cmd: begin
						rd_cnt[g_bank] <= '0;
						glb_rd_cnt <= '0;
					end
					write_cmd: begin
						wr_cnt[g_bank] <= '0;
						glb_wr_cnt <= '0;
					end
					precharge: begin
						pre_cnt[g_bank] <= '0;
						open_vld[g_bank] <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grant_valid_o && grant_cmd_o == activate) begin
			open_row[g_bank] <= slot_row_i[grant_slot_o];
		end
	end

endmodule
